// ==== hdl/dbg_defs.svh ====
/*
 * Sizing of the debug ring. Included by every RTL module that needs
 * the node count, register count or host word width.
 */

`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Ring stops, IDs 1 to this value, ID 0 is the host
`define DBG_NUM_NODES 4

// Registers in each ring stop
`define DBG_REGS_PER_NODE 4

// Host word and register data width
`define DBG_WORD_W 16

`endif

// ==== hdl/dbg_pkg.sv ====
/*
 * Types shared along the debug ring: opcodes, packetizer states and the
 * flit that moves from stop to stop. Imported by every RTL module.
 */

package dbg_pkg;

   // Requests come from the host, responses from a node or the serializer
   typedef enum logic [2:0] {
      OP_READ      = 3'd0,
      OP_WRITE     = 3'd1,
      OP_RESP_DATA = 3'd2,
      OP_RESP_ACK  = 3'd3,
      OP_RESP_ERR  = 3'd4
   } dbg_op_e;

   // Which host word the packetizer expects next
   typedef enum logic [1:0] {
      PKT_HDR,
      PKT_ADDR,
      PKT_DATA
   } pkt_state_e;

   // One ring slot, 44 bits
   typedef struct packed {
      logic        vld;
      dbg_op_e     op;
      logic [7:0]  dest;
      logic [7:0]  src;
      logic [7:0]  addr;
      logic [15:0] data;
   } dbg_flit_t;

endpackage

// ==== hdl/dbg_host_packetizer.sv ====
/*
 * Collects header, address and data words from the host and injects
 * one request flit at the head of the debug ring.
 */

`timescale 1ns/10ps

`include "dbg_defs.svh"

module dbg_host_packetizer import dbg_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   host_vld_i,
   input  logic [`DBG_WORD_W-1:0] host_word_i,
   output dbg_flit_t              flit_o
);

   pkt_state_e state_q;
   dbg_op_e    op_q;
   logic [7:0] dest_q;
   logic [7:0] addr_q;
   dbg_flit_t  flit_q;

   // Word sequencing
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= PKT_HDR;
      end else if (host_vld_i) begin
         case (state_q)
            PKT_HDR:  state_q <= PKT_ADDR;
            PKT_ADDR: state_q <= PKT_DATA;
            default:  state_q <= PKT_HDR;
         endcase
      end
   end

   // Header and address are held until the data word shows up
   always_ff @(posedge clk) begin
      if (host_vld_i && state_q == PKT_HDR) begin
         dest_q <= host_word_i[15:8];
         op_q   <= dbg_op_e'(host_word_i[2:0]);
      end
      if (host_vld_i && state_q == PKT_ADDR) begin
         addr_q <= host_word_i[7:0];
      end
   end

   // Slot is valid for exactly one cycle per request
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flit_q <= '0;
      end else if (host_vld_i && state_q == PKT_DATA) begin
         flit_q.vld  <= 1'b1;
         flit_q.op   <= op_q;
         flit_q.dest <= dest_q;
         flit_q.src  <= 8'd0;
         flit_q.addr <= addr_q;
         flit_q.data <= host_word_i;
      end else begin
         flit_q.vld <= 1'b0;
      end
   end

   assign flit_o = flit_q;

endmodule

// ==== hdl/dbg_reg_node.sv ====
/*
 * One stop on the debug ring with a small register file. Serves
 * requests for its own ID and forwards everything else after one cycle.
 */

`timescale 1ns/10ps

`include "dbg_defs.svh"

module dbg_reg_node import dbg_pkg::*; #(
   parameter int NODE_ID = 1
) (
   input  logic      clk,
   input  logic      arst_n_i,
   input  dbg_flit_t flit_i,
   output dbg_flit_t flit_o
);

   localparam int IDX_W = $clog2(`DBG_REGS_PER_NODE);

   // Register 0 is the read-only ID, so only 1 and up are stored
   logic [`DBG_WORD_W-1:0] regs_q [1:`DBG_REGS_PER_NODE-1];
   logic                   hit;
   logic                   in_range;
   logic                   wr_en;
   logic [IDX_W-1:0]       reg_idx;
   logic [`DBG_WORD_W-1:0] rd_data;
   dbg_flit_t              flit_d;
   dbg_flit_t              flit_q;

   assign hit      = flit_i.vld && (flit_i.dest == 8'(NODE_ID)) &&
                     (flit_i.op == OP_READ || flit_i.op == OP_WRITE);
   assign in_range = flit_i.addr < 8'(`DBG_REGS_PER_NODE);
   assign reg_idx  = flit_i.addr[IDX_W-1:0];
   assign wr_en    = hit && in_range && (flit_i.op == OP_WRITE);

   always_comb begin
      rd_data = `DBG_WORD_W'(NODE_ID);
      for (int i = 1; i < `DBG_REGS_PER_NODE; i++) begin
         if (reg_idx == IDX_W'(i)) begin
            rd_data = regs_q[i];
         end
      end
   end

   // Turn a claimed request into its response in the same slot
   always_comb begin
      flit_d = flit_i;
      if (hit) begin
         flit_d.src  = 8'(NODE_ID);
         flit_d.dest = 8'd0;
         flit_d.data = '0;
         if (!in_range) begin
            flit_d.op = OP_RESP_ERR;
         end else if (flit_i.op == OP_READ) begin
            flit_d.op   = OP_RESP_DATA;
            flit_d.data = rd_data;
         end else begin
            flit_d.op = OP_RESP_ACK;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < `DBG_REGS_PER_NODE; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         for (int i = 1; i < `DBG_REGS_PER_NODE; i++) begin
            if (wr_en && reg_idx == IDX_W'(i)) begin
               regs_q[i] <= flit_i.data;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flit_q <= '0;
      end else begin
         flit_q <= flit_d;
      end
   end

   assign flit_o = flit_q;

endmodule

// ==== hdl/dbg_host_serializer.sv ====
/*
 * Drains the end of the debug ring and sends each response to the host
 * as two words. Requests that nobody claimed are answered with an error.
 */

`timescale 1ns/10ps

`include "dbg_defs.svh"

module dbg_host_serializer import dbg_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  dbg_flit_t              flit_i,
   output logic                   resp_vld_o,
   output logic [`DBG_WORD_W-1:0] resp_word_o
);

   dbg_flit_t              resp_q;
   dbg_flit_t              resp_d;
   logic                   first_q;
   logic                   second_q;
   logic [`DBG_WORD_W-1:0] word1;

   // Still a request here means no node matched the dest
   always_comb begin
      resp_d = flit_i;
      if (flit_i.op == OP_READ || flit_i.op == OP_WRITE) begin
         resp_d.op   = OP_RESP_ERR;
         resp_d.src  = flit_i.dest;
         resp_d.data = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (flit_i.vld) begin
         resp_q <= resp_d;
      end
   end

   assign word1 = {resp_q.src, 5'd0, resp_q.op};

   // Flits arrive at least three cycles apart, so two word slots never overlap
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         first_q    <= 1'b0;
         second_q   <= 1'b0;
         resp_vld_o <= 1'b0;
      end else begin
         first_q    <= flit_i.vld;
         second_q   <= first_q;
         resp_vld_o <= first_q | second_q;
      end
   end

   always_ff @(posedge clk) begin
      resp_word_o <= first_q ? word1 : resp_q.data;
   end

endmodule

// ==== hdl/dbg_ring_top.sv ====
/*
 * Debug ring top level. Host words go in through the packetizer, pass
 * the chain of register nodes and come back out of the serializer.
 */

`timescale 1ns/10ps

`include "dbg_defs.svh"

module dbg_ring_top import dbg_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   host_vld_i,
   input  logic [`DBG_WORD_W-1:0] host_word_i,
   output logic                   resp_vld_o,
   output logic [`DBG_WORD_W-1:0] resp_word_o
);

   // Slot 0 is the ring head, slot k is the output of node k
   dbg_flit_t ring [`DBG_NUM_NODES+1];

   dbg_host_packetizer u_packetizer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .host_vld_i  (host_vld_i),
      .host_word_i (host_word_i),
      .flit_o      (ring[0])
   );

   for (genvar i = 0; i < `DBG_NUM_NODES; i++) begin : g_node
      dbg_reg_node #(
         .NODE_ID (i + 1)
      ) u_node (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .flit_i   (ring[i]),
         .flit_o   (ring[i+1])
      );
   end

   dbg_host_serializer u_serializer (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .flit_i      (ring[`DBG_NUM_NODES]),
      .resp_vld_o  (resp_vld_o),
      .resp_word_o (resp_word_o)
   );

endmodule

// ==== bench/tb_dbg_ring.sv ====
/*
 * Testbench for the debug ring. Reads request words and expected response
 * words from the case file, drives the host port and checks every response.
 */

`timescale 1ns/10ps

`include "dbg_defs.svh"

module tb_dbg_ring;

   logic                   clk;
   logic                   arst_n_i;
   logic                   host_vld_i;
   logic [`DBG_WORD_W-1:0] host_word_i;
   logic                   resp_vld_o;
   logic [`DBG_WORD_W-1:0] resp_word_o;

   // Case table, three request words and two expected words per case
   logic [`DBG_WORD_W-1:0] req_words[$];
   logic [`DBG_WORD_W-1:0] exp_words[$];
   bit                     no_gap[$];

   // Outstanding response words and the cycle each word is due
   logic [`DBG_WORD_W-1:0] exp_q[$];
   int                     due_q[$];

   logic [15:0] lfsr_state = 16'd86;
   int          cycle = 0;
   int          cycle_limit = 1000000;

   dbg_ring_top uut (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .host_vld_i  (host_vld_i),
      .host_word_i (host_word_i),
      .resp_vld_o  (resp_vld_o),
      .resp_word_o (resp_word_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   task automatic take_bits(input int count, output int value);
      value = 0;
      for (int i = 0; i < count; i++) begin
         value = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic read_cases(input int fd);
      string       line;
      string       tok;
      int          n;
      bit          burst;
      logic [15:0] hdr;
      logic [15:0] adr;
      logic [15:0] dat;
      logic [15:0] e1;
      logic [15:0] e2;
      burst = 1'b0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%h %h %h %h %h", hdr, adr, dat, e1, e2);
         if (n == 5) begin
            req_words.push_back(hdr);
            req_words.push_back(adr);
            req_words.push_back(dat);
            exp_words.push_back(e1);
            exp_words.push_back(e2);
            no_gap.push_back(burst);
         end else if ($sscanf(line, "%s", tok) == 1 && tok == "burst") begin
            burst = 1'b1;
         end
      end
   endtask

   task automatic drive_word(input logic [`DBG_WORD_W-1:0] word);
      @(posedge clk);
      #1;
      host_vld_i  = 1'b1;
      host_word_i = word;
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #1;
         host_vld_i  = 1'b0;
         host_word_i = '0;
      end
   endtask

   // Response monitor, outputs are settled at the falling edge
   always @(negedge clk) begin : check_resp
      logic [`DBG_WORD_W-1:0] exp_word;
      int                     due;
      if (resp_vld_o === 1'b1) begin
         assert (exp_q.size() > 0) else begin
            $display("Response word seen while no request was outstanding");
            $display("*** FAILED ***");
            $fatal(1);
         end
         exp_word = exp_q.pop_front();
         due      = due_q.pop_front();
         assert (cycle == due) else begin
            $display("Response word arrived at cycle %0d but was due at cycle %0d",
                     cycle, due);
            $display("*** FAILED ***");
            $fatal(1);
         end
         assert (resp_word_o === exp_word) else begin
            $display("[FAIL] resp_word_o expected %h got %h", exp_word, resp_word_o);
            $display("*** FAILED ***");
            $fatal(1);
         end
      end
   end

   always @(negedge clk) begin
      assert (cycle <= cycle_limit) else begin
         $display("Timeout after %0d cycles with responses still missing", cycle);
         $display("*** FAILED ***");
         $fatal(1);
      end
   end

   initial begin
      int fd;
      int gap;
      host_vld_i  = 1'b0;
      host_word_i = '0;
      arst_n_i    = 1'b0;
      fd = $fopen("bench/dbg_ring_cases.txt", "r");
      assert (fd != 0) else begin
         $display("Could not open the case file bench/dbg_ring_cases.txt");
         $display("*** FAILED ***");
         $fatal(1);
      end
      read_cases(fd);
      $fclose(fd);
      cycle_limit = (exp_words.size() / 2) * 15 + `DBG_NUM_NODES + 50;

      repeat (10) @(posedge clk);
      #1;
      arst_n_i = 1'b1;

      for (int c = 0; c < no_gap.size(); c++) begin
         for (int k = 0; k < 3; k++) begin
            gap = 0;
            if (!no_gap[c]) begin
               take_bits(2, gap);
            end
            drive_idle(gap);
            drive_word(req_words[3*c+k]);
         end
         // Third word is sampled at the next edge, word 2 follows word 1
         exp_q.push_back(exp_words[2*c]);
         exp_q.push_back(exp_words[2*c+1]);
         due_q.push_back(cycle + 1 + `DBG_NUM_NODES + 2);
         due_q.push_back(cycle + 1 + `DBG_NUM_NODES + 3);
      end
      drive_idle(1);

      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      // Quiet tail catches a stray extra word
      repeat (5) @(negedge clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== bench/dbg_ring_cases.txt ====
// hdr addr data exp_word1 exp_word2, all hex, hdr = dest<<8 | op (0 read, 1 write)
// a line reading burst sends all cases below it with no idle gaps
0100 0001 0000 0102 0000
0200 0002 0000 0202 0000
0400 0003 0000 0402 0000
0101 0001 1111 0103 0000
0201 0002 2222 0203 0000
0301 0003 3333 0303 0000
0401 0001 4444 0403 0000
0101 0003 a5a5 0103 0000
0100 0001 0000 0102 1111
0200 0002 ffff 0202 2222
0300 0003 0000 0302 3333
0400 0001 0000 0402 4444
0100 0003 0000 0102 a5a5
0100 0002 0000 0102 0000
0300 0000 0000 0302 0003
0201 0000 dead 0203 0000
0200 0000 0000 0202 0002
0100 0000 0000 0102 0001
0200 0004 0000 0204 0000
0401 00ff 1234 0404 0000
0000 0001 0000 0004 0000
0501 0001 5555 0504 0000
ff00 0002 0000 ff04 0000
burst
0101 0002 0bad 0103 0000
0400 0001 0000 0402 4444
0100 0002 0000 0102 0bad
0600 0001 0000 0604 0000
0301 0001 7777 0303 0000
0300 0001 0000 0302 7777
0200 0004 0000 0204 0000

// ==== src.f ====
+incdir+hdl
hdl/dbg_pkg.sv
hdl/dbg_host_packetizer.sv
hdl/dbg_reg_node.sv
hdl/dbg_host_serializer.sv
hdl/dbg_ring_top.sv
bench/tb_dbg_ring.sv

// ==== Makefile ====
# Verilator build and run of the debug ring testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_dbg_ring
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** PASSED ***' $(LOG); then \
	   echo "Simulation run passed"; \
	else \
	   echo "Simulation run failed, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
